// ==== sources.f ====
source/lcd_note_pkg.sv
source/pixel_if.sv
source/lcd_timing_gen.sv
source/note_table.sv
source/bar_renderer.sv
source/lcd_note_display.sv
testbench/tb_lcd_note_display.sv

// ==== testbench/tb_lcd_note_display.sv ====
`default_nettype none

module tb_lcd_note_display;

	localparam integer H_ACT   = 64;
	localparam integer V_ACT   = 32;
	localparam integer H_TOT   = 64 + 4 + 4 + 4;
	localparam integer V_TOT   = 32 + 2 + 2 + 2;
	localparam integer TIMEOUT = 3 * H_TOT * V_TOT;  // cycles, about three frames

	logic        clk;
	logic        rst_n;
	logic        note_valid;
	logic        note_ready;
	logic [3:0]  note_index;
	logic        note_lane;
	logic        note_color;
	logic [11:0] note_x_left;
	logic [11:0] note_x_right;
	logic        hsync;
	logic        vsync;
	logic        de;
	logic [23:0] rgb;

	// testbench copy of the note table
	logic        ref_lane [16];
	logic        ref_color [16];
	int          ref_xl [16];
	int          ref_xr [16];

	int          errors;
	int          pix_checked;
	int          mon_x;
	int          mon_y;
	int          out_col;
	logic        prev_de;
	logic        check_en;
	logic [31:0] rand_state;

	lcd_note_display
	#(
		.H_ACTIVE (64),
		.H_FRONT  (4),
		.H_SYNC   (4),
		.H_BACK   (4),
		.V_ACTIVE (32),
		.V_FRONT  (2),
		.V_SYNC   (2),
		.V_BACK   (2)
	)
	lcd_note_display_i
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.note_valid   (note_valid),
		.note_ready   (note_ready),
		.note_index   (note_index),
		.note_lane    (note_lane),
		.note_color   (note_color),
		.note_x_left  (note_x_left),
		.note_x_right (note_x_right),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.rgb          (rgb)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// strict coverage, black over red over white
	function automatic logic [23:0] pixel_color(input int x, input int y);
		logic any_black;
		logic any_red;
		logic in_band;
		any_black = 1'b0;
		any_red   = 1'b0;
		for (int i = 0; i < 16; i++)
		begin
			if (ref_lane[i] == 1'b0)
				in_band = (y > V_ACT / 4) && (y < V_ACT / 2);
			else
				in_band = (y > V_ACT / 2) && (y < (3 * V_ACT) / 4);
			if (in_band && (x > ref_xl[i]) && (x < ref_xr[i]))
			begin
				if (ref_color[i])
					any_red = 1'b1;
				else
					any_black = 1'b1;
			end
		end
		if (any_black)
			return 24'h000000;
		else if (any_red)
			return 24'hff0000;
		return 24'hffffff;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			errors++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name,
				expected, actual);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("errors: %0d, pixels checked: %0d", errors, pix_checked);
		$display("Test FAILED");
		$finish;
	endtask

	// output position is tracked from de and vsync alone
	always @(negedge clk)
	begin
		if (rst_n && vsync)
		begin
			mon_x <= 0;
			mon_y <= 0;
		end
		else if (rst_n && de)
		begin
			if (check_en)
			begin
				compare("rgb", {8'h00, pixel_color(mon_x, mon_y)}, {8'h00, rgb});
				pix_checked <= pix_checked + 1;
			end
			mon_x <= mon_x + 1;
		end
		else if (rst_n && prev_de)
		begin
			mon_x <= 0;
			mon_y <= mon_y + 1;  // line done
		end
		prev_de <= de;
	end

	// output column, restarted by the first de of each line
	always @(negedge clk)
	begin
		if (de && !prev_de)
			out_col = 0;
		if (rst_n && check_en)
			compare("hsync", (out_col >= H_ACT + 4) && (out_col < H_ACT + 8), hsync);  // 4 porch, 4 sync
		out_col = (out_col + 1) % H_TOT;
	end

	task automatic wait_vsync(input logic level);
		int n;
		n = 0;
		while (vsync !== level)
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_run("vsync never reached the expected level");
		end
	endtask

	task automatic wait_de_high();
		int n;
		n = 0;
		while (de !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_run("de never went high");
		end
	endtask

	// checks every pixel until the next vsync
	task automatic check_until_vsync();
		int start;
		start    = pix_checked;
		check_en = 1'b1;
		wait_vsync(1'b1);
		check_en = 1'b0;
		@(negedge clk);
		compare("pixel_count", H_ACT * V_ACT, pix_checked - start);
	endtask

	task automatic check_frame();
		wait_vsync(1'b1);
		wait_vsync(1'b0);
		check_until_vsync();
	endtask

	task automatic write_note(input int idx, input logic lane, input logic color,
		input int xl, input int xr, input logic in_active);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		note_valid   = 1'b1;
		note_index   = idx[3:0];
		note_lane    = lane;
		note_color   = color;
		note_x_left  = xl[11:0];
		note_x_right = xr[11:0];
		if (in_active)
			compare("note_ready", 0, note_ready);  // back-pressure while drawing
		@(negedge clk);
		while (note_ready !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_run("note write was never accepted");
		end
		if (in_active)
			compare("mon_y", V_ACT, mon_y);  // whole frame went out first
		@(posedge clk);
		ref_lane[idx]  = lane;
		ref_color[idx] = color;
		ref_xl[idx]    = xl;
		ref_xr[idx]    = xr;
		#1;
		note_valid = 1'b0;
	endtask

	initial
	begin
		int xl;
		clk          = 1'b0;
		rst_n        = 1'b0;
		note_valid   = 1'b0;
		note_index   = '0;
		note_lane    = 1'b0;
		note_color   = 1'b0;
		note_x_left  = '0;
		note_x_right = '0;
		errors       = 0;
		pix_checked  = 0;
		mon_x        = 0;
		mon_y        = 0;
		out_col      = 0;
		prev_de      = 1'b0;
		check_en     = 1'b0;
		rand_state   = 32'ha7f1;
		for (int i = 0; i < 16; i++)
		begin
			ref_lane[i]  = 1'b0;
			ref_color[i] = 1'b0;
			ref_xl[i]    = 0;
			ref_xr[i]    = 0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// reset state, then the first frame is all white
		compare("de", 0, de);
		compare("hsync", 0, hsync);
		compare("vsync", 0, vsync);
		compare("rgb", 0, rgb);
		compare("note_ready", 0, note_ready);
		check_until_vsync();

		// black bar, upper lane
		write_note(0, 1'b0, 1'b0, 10, 20, 1'b0);
		check_frame();

		// red bar in lower lane, black one overlapping it
		write_note(1, 1'b1, 1'b1, 30, 50, 1'b0);
		write_note(2, 1'b1, 1'b0, 40, 60, 1'b0);
		check_frame();

		// write offered mid-frame waits for blanking
		wait_vsync(1'b1);
		wait_vsync(1'b0);
		wait_de_high();
		check_en = 1'b1;
		write_note(3, 1'b0, 1'b1, 50, 62, 1'b1);
		check_frame();

		// overwrite, then remove with an empty span
		write_note(0, 1'b0, 1'b1, 5, 25, 1'b0);
		check_frame();
		write_note(0, 1'b0, 1'b1, 33, 33, 1'b0);
		check_frame();

		// random fill of the whole table, lane and color from upper bits
		for (int i = 0; i < 16; i++)
		begin
			xl = next_rand() % 70;
			write_note(i, (next_rand() >> 16) & 1, (next_rand() >> 16) & 1, xl,
				xl + next_rand() % 30, 1'b0);
		end
		check_frame();

		$display("errors: %0d, pixels checked: %0d", errors, pix_checked);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/lcd_note_display.sv ====
`default_nettype none

module lcd_note_display
#(
	parameter integer H_ACTIVE = 1280,
	parameter integer H_FRONT  = 110,
	parameter integer H_SYNC   = 40,
	parameter integer H_BACK   = 220,
	parameter integer V_ACTIVE = 720,
	parameter integer V_FRONT  = 5,
	parameter integer V_SYNC   = 5,
	parameter integer V_BACK   = 20
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        note_valid,
	output logic        note_ready,
	input  logic [3:0]  note_index,
	input  logic        note_lane,   // 0 upper, 1 lower
	input  logic        note_color,  // 0 black, 1 red
	input  logic [11:0] note_x_left,
	input  logic [11:0] note_x_right,
	output logic        hsync,
	output logic        vsync,
	output logic        de,
	output logic [23:0] rgb
);
	import lcd_note_pkg::*;

	logic        vblank;
	note_entry_t note_entry;
	note_table_t notes;

	pixel_if pix ();

	assign note_entry = '{
		lane:    note_lane_e'(note_lane),
		color:   note_color_e'(note_color),
		x_left:  note_x_left,
		x_right: note_x_right
	};

	lcd_timing_gen
	#(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	)
	lcd_timing_gen_i
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.pix    (pix),
		.vblank (vblank)
	);

	note_table note_table_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.vblank     (vblank),
		.note_valid (note_valid),
		.note_ready (note_ready),
		.note_index (note_index),
		.note_entry (note_entry),
		.notes      (notes)
	);

	bar_renderer
	#(
		.V_ACTIVE (V_ACTIVE)
	)
	bar_renderer_i
	(
		.clk   (clk),
		.rst_n (rst_n),
		.pix   (pix),
		.notes (notes),
		.rgb   (rgb),
		.de    (de),
		.hsync (hsync),
		.vsync (vsync)
	);

endmodule

`default_nettype wire

// ==== source/bar_renderer.sv ====
`default_nettype none

module bar_renderer
#(
	parameter integer V_ACTIVE = 720
)
(
	input  logic                      clk,
	input  logic                      rst_n,
	pixel_if.sink                     pix,
	input  lcd_note_pkg::note_table_t notes,
	output lcd_note_pkg::rgb_t        rgb,
	output logic                      de,
	output logic                      hsync,
	output logic                      vsync
);
	import lcd_note_pkg::*;

	// band edges, all exclusive
	localparam coord_t BAND_TOP = coord_t'(V_ACTIVE / 4);
	localparam coord_t BAND_MID = coord_t'(V_ACTIVE / 2);
	localparam coord_t BAND_BOT = coord_t'((3 * V_ACTIVE) / 4);

	logic                  in_upper;
	logic                  in_lower;
	logic [NOTE_COUNT-1:0] in_span;
	logic [NOTE_COUNT-1:0] in_band;
	logic [NOTE_COUNT-1:0] black_hit_c;
	logic [NOTE_COUNT-1:0] red_hit_c;

	logic [NOTE_COUNT-1:0] black_hit_q;  // stage 1
	logic [NOTE_COUNT-1:0] red_hit_q;
	logic                  de_q;
	logic                  hsync_q;
	logic                  vsync_q;

	rgb_t                  rgb_c;

	assign in_upper = (pix.y > BAND_TOP) && (pix.y < BAND_MID);
	assign in_lower = (pix.y > BAND_MID) && (pix.y < BAND_BOT);

	// per-entry coverage test, split by color
	always_comb
	begin
		for (int i = 0; i < NOTE_COUNT; i++)
		begin
			in_span[i] = (pix.x > notes[i].x_left) && (pix.x < notes[i].x_right);
			in_band[i] = (notes[i].lane == lane_upper) ? in_upper : in_lower;
			black_hit_c[i] = in_span[i] && in_band[i] &&
			                 (notes[i].color == color_black);
			red_hit_c[i] = in_span[i] && in_band[i] &&
			               (notes[i].color == color_red);
		end
	end

	// stage 1: hit vectors with sync alongside
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			black_hit_q <= '0;
			red_hit_q   <= '0;
			de_q        <= 1'b0;
			hsync_q     <= 1'b0;
			vsync_q     <= 1'b0;
		end
		else
		begin
			black_hit_q <= black_hit_c;
			red_hit_q   <= red_hit_c;
			de_q        <= pix.de;
			hsync_q     <= pix.hsync;
			vsync_q     <= pix.vsync;
		end
	end

	// black beats red, white is background
	always_comb
	begin
		if (!de_q)
			rgb_c = '0;  // blank outside active video
		else if (|black_hit_q)
			rgb_c = RGB_BLACK;
		else if (|red_hit_q)
			rgb_c = RGB_RED;
		else
			rgb_c = RGB_WHITE;
	end

	// stage 2: color and the twice-delayed sync
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rgb   <= '0;
			de    <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			rgb   <= rgb_c;
			de    <= de_q;
			hsync <= hsync_q;
			vsync <= vsync_q;
		end
	end

	a_rgb_blank: assert property (
		@(posedge clk) disable iff (!rst_n)
		!de |-> (rgb == '0)
	);

endmodule

`default_nettype wire

// ==== source/note_table.sv ====
`default_nettype none

module note_table
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      vblank,
	input  logic                      note_valid,
	output logic                      note_ready,
	input  lcd_note_pkg::note_index_t note_index,
	input  lcd_note_pkg::note_entry_t note_entry,
	output lcd_note_pkg::note_table_t notes
);
	import lcd_note_pkg::*;

	logic wr_fire;

	// writes only land between frames
	assign note_ready = vblank;
	assign wr_fire    = note_valid && note_ready;

	// cleared entries have x_left == x_right, so they cover nothing
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			notes <= '0;
		end
		else if (wr_fire)
		begin
			notes[note_index] <= note_entry;
		end
	end

	// a frame must never show a half-updated table
	a_write_in_vblank: assert property (
		@(posedge clk) disable iff (!rst_n)
		!vblank |=> $stable(notes)
	);

	// sender keeps the request steady under back-pressure
	a_valid_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(note_valid && !note_ready) |=>
			(note_valid && $stable(note_index) && $stable(note_entry))
	);

endmodule

`default_nettype wire

// ==== source/lcd_timing_gen.sv ====
`default_nettype none

module lcd_timing_gen
#(
	parameter integer H_ACTIVE = 1280,
	parameter integer H_FRONT  = 110,
	parameter integer H_SYNC   = 40,
	parameter integer H_BACK   = 220,
	parameter integer V_ACTIVE = 720,
	parameter integer V_FRONT  = 5,
	parameter integer V_SYNC   = 5,
	parameter integer V_BACK   = 20
)
(
	input  logic    clk,
	input  logic    rst_n,
	pixel_if.source pix,
	output logic    vblank
);
	import lcd_note_pkg::*;

	localparam integer H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam integer V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam integer H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam integer V_SYNC_START = V_ACTIVE + V_FRONT;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_last;  // last clock of a line
	logic   v_last;  // last line of a frame
	logic   h_active;
	logic   v_active;

	assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
	assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

	// one pixel per clock, line counter steps at end of line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			if (v_last)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end
		else
		begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign h_active = (h_cnt < coord_t'(H_ACTIVE));
	assign v_active = (v_cnt < coord_t'(V_ACTIVE));

	assign pix.de    = h_active && v_active;
	assign pix.hsync = (h_cnt >= coord_t'(H_SYNC_START)) &&
	                   (h_cnt < coord_t'(H_SYNC_START + H_SYNC));
	assign pix.vsync = (v_cnt >= coord_t'(V_SYNC_START)) &&
	                   (v_cnt < coord_t'(V_SYNC_START + V_SYNC));
	assign pix.x     = h_cnt;  // only meaningful while de
	assign pix.y     = v_cnt;

	assign vblank = !v_active;  // note table may change now

	// the table updates in vblank, so active video must never overlap it
	a_de_outside_vblank: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(pix.de && vblank)
	);

endmodule

`default_nettype wire

// ==== source/pixel_if.sv ====
`default_nettype none

// raster position and sync, timing generator to renderer
interface pixel_if;
	import lcd_note_pkg::*;

	logic   de;     // inside active area
	logic   hsync;  // active high
	logic   vsync;  // active high
	coord_t x;
	coord_t y;

	modport source
	(
		output de,
		output hsync,
		output vsync,
		output x,
		output y
	);

	modport sink
	(
		input de,
		input hsync,
		input vsync,
		input x,
		input y
	);

endinterface

`default_nettype wire

// ==== source/lcd_note_pkg.sv ====
`default_nettype none

package lcd_note_pkg;

	// pixel coordinate, wide enough for 720p totals
	typedef logic [11:0] coord_t;

	typedef enum logic
	{
		lane_upper = 1'b0,
		lane_lower = 1'b1
	} note_lane_e;

	typedef enum logic
	{
		color_black = 1'b0,
		color_red   = 1'b1
	} note_color_e;

	// lane and color sit on top, same order as the old 26-bit note word
	typedef struct packed
	{
		note_lane_e  lane;
		note_color_e color;
		coord_t      x_left;   // exclusive
		coord_t      x_right;  // exclusive
	} note_entry_t;

	localparam int NOTE_COUNT = 16;

	typedef logic [3:0] note_index_t;

	// whole table as one flat vector, 416 bits
	typedef note_entry_t [NOTE_COUNT-1:0] note_table_t;

	typedef logic [23:0] rgb_t;  // r in [23:16], g in [15:8], b in [7:0]

	localparam rgb_t RGB_WHITE = 24'hff_ff_ff;
	localparam rgb_t RGB_BLACK = 24'h00_00_00;
	localparam rgb_t RGB_RED   = 24'hff_00_00;

endpackage

`default_nettype wire
